//--- bank_router.sv
`include "mem_defs.svh"

module bank_router (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req,
    input  mem_pkg::mem_req_t         req_data,
    output logic [`MEM_NO_BANKS-1:0]  bank_sel,
    output mem_pkg::mem_req_t         bank_req,
    output mem_pkg::rsp_tag_t         rsp_tag
);
    import mem_pkg::*;

    // low address bits select a byte within the word
    localparam int OFF_W  = $clog2(`MEM_STRB_W);
    localparam int WORD_W = `MEM_ADDR_W - OFF_W;

    // one extra bit so the limit itself always fits
    localparam logic [WORD_W:0] TOTAL_WORDS =
        (WORD_W+1)'(`MEM_NO_BANKS * `MEM_BANK_WORDS);

    logic [WORD_W-1:0]          word_idx;
    logic [WORD_W-1:0]          bank_full;
    logic [WORD_W-1:0]          word_in_bank;
    logic [`MEM_BANK_IDX_W-1:0] bank_idx;
    logic                       out_of_range;
    logic                       accept;

    // byte address to global word index
    assign word_idx = req_data.addr[`MEM_ADDR_W-1:OFF_W];

    // banks are stacked, each one a contiguous block of words
    assign bank_full    = word_idx / WORD_W'(`MEM_BANK_WORDS);
    assign word_in_bank = word_idx % WORD_W'(`MEM_BANK_WORDS);
    assign bank_idx     = bank_full[`MEM_BANK_IDX_W-1:0];

    // the single range check, also guards the truncated bank index
    assign out_of_range = ({1'b0, word_idx} >= TOTAL_WORDS);
    assign accept       = req && !out_of_range;

    // one-hot select, nothing for a rejected request
    always_comb begin
        bank_sel = '0;
        if (accept) begin
            bank_sel[bank_idx] = 1'b1;
        end
    end

    // same request to all banks, address rebased to the bank
    always_comb begin
        bank_req      = req_data;
        bank_req.addr = `MEM_ADDR_W'(word_in_bank);
    end

    // tag follows the request by one cycle, like the bank read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_tag <= '0;
        end else begin
            rsp_tag.valid <= req;
            rsp_tag.read  <= req && (req_data.op == op_read);
            rsp_tag.error <= req && out_of_range;
            rsp_tag.bank  <= bank_idx;
        end
    end

endmodule

//--- mem_bank.sv
`include "mem_defs.svh"

module mem_bank #(
    parameter int WORDS = `MEM_BANK_WORDS
) (
    input  logic                    clk,
    input  logic                    sel,
    input  mem_pkg::mem_req_t       bank_req,
    output logic [`MEM_DATA_W-1:0]  rdata
);
    import mem_pkg::*;

    // keep at least one address bit for a single-word bank
    localparam int AW = (WORDS > 1) ? $clog2(WORDS) : 1;

    logic [`MEM_DATA_W-1:0] mem [WORDS];
    logic [AW-1:0]          word_addr;
    logic                   do_write;
    logic                   do_read;

    // router has already rebased the address to this bank
    assign word_addr = bank_req.addr[AW-1:0];

    assign do_write = sel && (bank_req.op == op_write);
    assign do_read  = sel && (bank_req.op == op_read);

    // byte-masked write, only enabled lanes change
    always_ff @(posedge clk) begin
        if (do_write) begin
            for (int b = 0; b < `MEM_STRB_W; b++) begin
                if (bank_req.be[b]) begin
                    mem[word_addr][8*b +: 8] <= bank_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read port, one cycle latency
    // output only changes on a selected read
    always_ff @(posedge clk) begin
        if (do_read) begin
            rdata <= mem[word_addr];
        end
    end

endmodule

//--- mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// byte address width seen by the requester
`define MEM_ADDR_W 32

// data word width
`define MEM_DATA_W 32

// one enable bit per data byte
`define MEM_STRB_W (`MEM_DATA_W / 8)

// number of banks in the subsystem
`define MEM_NO_BANKS 4

// words held by each bank
`define MEM_BANK_WORDS 1024

// width of a bank index, must cover MEM_NO_BANKS
`define MEM_BANK_IDX_W 2

`endif

//--- mem_pkg.sv
`include "mem_defs.svh"

package mem_pkg;

    // operation carried by a request
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    // one request, as issued at the top level
    // the router reuses it towards the banks with addr holding the in-bank word
    typedef struct packed {
        mem_op_e                 op;
        logic [`MEM_ADDR_W-1:0]  addr;
        logic [`MEM_STRB_W-1:0]  be;
        logic [`MEM_DATA_W-1:0]  wdata;
    } mem_req_t;

    // what the router knows about last cycle's request
    typedef struct packed {
        logic                        valid;
        logic                        read;
        logic                        error;
        logic [`MEM_BANK_IDX_W-1:0]  bank;
    } rsp_tag_t;

endpackage

//--- mem_subsys.sv
`include "mem_defs.svh"

module mem_subsys (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req,
    input  mem_pkg::mem_req_t       req_data,
    output logic                    rvalid,
    output logic [`MEM_DATA_W-1:0]  rdata,
    output logic                    err
);
    import mem_pkg::*;

    logic [`MEM_NO_BANKS-1:0] bank_sel;
    mem_req_t                 bank_req;
    rsp_tag_t                 rsp_tag;
    logic [`MEM_DATA_W-1:0]   bank_rdata [`MEM_NO_BANKS];

    // address decode and response tag
    bank_router u_bank_router (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .bank_sel (bank_sel),
        .bank_req (bank_req),
        .rsp_tag  (rsp_tag)
    );

    // identical banks, all share the request bus
    for (genvar i = 0; i < `MEM_NO_BANKS; i++) begin : g_bank
        mem_bank #(
            .WORDS (`MEM_BANK_WORDS)
        ) u_mem_bank (
            .clk      (clk),
            .sel      (bank_sel[i]),
            .bank_req (bank_req),
            .rdata    (bank_rdata[i])
        );
    end

    // read data return and error pulse
    rsp_collector u_rsp_collector (
        .clk        (clk),
        .rst_n      (rst_n),
        .rsp_tag    (rsp_tag),
        .bank_rdata (bank_rdata),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .err        (err)
    );

endmodule

//--- mem_subsys_tb.sv
`include "mem_defs.svh"

module mem_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mem_pkg::*;

    localparam int unsigned BANK_WORDS    = `MEM_BANK_WORDS;
    localparam int unsigned TOTAL_WORDS   = `MEM_NO_BANKS * `MEM_BANK_WORDS;
    localparam int          RESET_TIMEOUT = 20;
    localparam int          QUIET_TIMEOUT = 20;

    // outputs the DUT should show in the cycle after a request
    typedef struct packed {
        logic                   rvalid;
        logic                   err;
        logic [`MEM_DATA_W-1:0] rdata;
    } expect_t;

    logic                   clk;
    logic                   rst_n;
    logic                   req;
    mem_req_t               req_data;
    logic                   rvalid;
    logic [`MEM_DATA_W-1:0] rdata;
    logic                   err;

    expect_t                exp_next;
    expect_t                exp_q;
    logic [`MEM_DATA_W-1:0] hold_data;
    logic [`MEM_DATA_W-1:0] ref_mem [int unsigned];

    int rvalid_errs;
    int err_errs;
    int rdata_errs;
    int timeout_errs;

    tb_clk_gen u_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_subsys u_mem_subsys (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .rvalid   (rvalid),
        .rdata    (rdata),
        .err      (err)
    );

    // one-deep expected queue lined up with the DUT response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q <= '0;
        end else begin
            exp_q <= exp_next;
        end
    end

    rvalid_chk: assert property (@(posedge clk) disable iff (!rst_n) rvalid == exp_q.rvalid)
        else begin
            rvalid_errs = rvalid_errs + 1;
            $display("Fail %0t rvalid expected %0b actual %0b",
                     $time, $sampled(exp_q.rvalid), $sampled(rvalid));
        end

    err_chk: assert property (@(posedge clk) disable iff (!rst_n) err == exp_q.err)
        else begin
            err_errs = err_errs + 1;
            $display("Fail %0t err expected %0b actual %0b",
                     $time, $sampled(exp_q.err), $sampled(err));
        end

    rdata_chk: assert property (@(posedge clk) disable iff (!rst_n) rdata == exp_q.rdata)
        else begin
            rdata_errs = rdata_errs + 1;
            $display("Fail %0t rdata expected %08h actual %08h",
                     $time, $sampled(exp_q.rdata), $sampled(rdata));
        end

    // byte-enable merge into the reference word
    function automatic void merge_write(input int unsigned idx,
                                        input logic [`MEM_STRB_W-1:0] be,
                                        input logic [`MEM_DATA_W-1:0] wdata);
        logic [`MEM_DATA_W-1:0] word;
        word = ref_mem.exists(idx) ? ref_mem[idx] : '0;
        for (int b = 0; b < `MEM_STRB_W; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        ref_mem[idx] = word;
    endfunction

    // random byte offset within the word
    function automatic logic [`MEM_ADDR_W-1:0] word_addr(input int unsigned idx);
        return (idx << 2) | ($urandom % 4);
    endfunction

    task automatic issue(input mem_op_e op, input logic [`MEM_ADDR_W-1:0] addr,
                         input logic [`MEM_STRB_W-1:0] be,
                         input logic [`MEM_DATA_W-1:0] wdata);
        mem_req_t    r;
        expect_t     e;
        int unsigned idx;
        r.op    = op;
        r.addr  = addr;
        r.be    = be;
        r.wdata = wdata;
        idx     = addr >> 2;
        e       = '0;
        e.rdata = hold_data;
        if (idx >= TOTAL_WORDS) begin
            e.err = 1'b1;
        end else if (op == op_write) begin
            merge_write(idx, be, wdata);
        end else begin
            e.rvalid  = 1'b1;
            e.rdata   = ref_mem[idx];
            hold_data = ref_mem[idx];
        end
        @(posedge clk);
        req      <= 1'b1;
        req_data <= r;
        exp_next <= e;
    endtask

    task automatic idle(input int cycles);
        expect_t e;
        e       = '0;
        e.rdata = hold_data;
        repeat (cycles) begin
            @(posedge clk);
            req      <= 1'b0;
            exp_next <= e;
        end
    endtask

    task automatic write_word(input int unsigned idx, input logic [`MEM_STRB_W-1:0] be,
                              input logic [`MEM_DATA_W-1:0] wdata);
        issue(op_write, word_addr(idx), be, wdata);
    endtask

    // unknown words get written first since memory is not reset
    task automatic read_word(input int unsigned idx);
        if (!ref_mem.exists(idx)) begin
            write_word(idx, '1, $urandom);
        end
        issue(op_read, word_addr(idx), '0, $urandom);
    endtask

    task automatic wait_reset_release(output bit ok);
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        ok = (rst_n === 1'b1);
        if (!ok) begin
            timeout_errs++;
            $display("timeout: reset still active after %0d cycles", RESET_TIMEOUT);
        end
    endtask

    task automatic wait_quiet();
        int cycles;
        cycles = 0;
        while ((rvalid || err) && cycles < QUIET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rvalid || err) begin
            timeout_errs++;
            $display("timeout: responses still arriving after %0d idle cycles", QUIET_TIMEOUT);
        end
    endtask

    task automatic full_and_partial_writes();
        int unsigned idx;
        for (int i = 0; i < 8; i++) begin
            idx = $urandom % TOTAL_WORDS;
            write_word(idx, '1, $urandom);
            read_word(idx);
            write_word(idx, `MEM_STRB_W'($urandom), $urandom);
            read_word(idx);
            idle(1);
        end
    endtask

    // same offset and last word in every bank then scattered words
    task automatic bank_spread();
        int unsigned offset;
        int unsigned picks[$];
        offset = $urandom % BANK_WORDS;
        for (int b = 0; b < `MEM_NO_BANKS; b++) begin
            picks.push_back(b * BANK_WORDS + offset);
            picks.push_back(b * BANK_WORDS + BANK_WORDS - 1);
        end
        for (int i = 0; i < 16; i++) begin
            picks.push_back($urandom % TOTAL_WORDS);
        end
        foreach (picks[i]) begin
            write_word(picks[i], '1, $urandom);
        end
        idle(2);
        foreach (picks[i]) begin
            read_word(picks[i]);
            if (i % 5 == 4) begin
                idle(3);
            end
        end
        idle(2);
    endtask

    // rejected requests must leave every known word alone
    task automatic out_of_range();
        logic [`MEM_ADDR_W-1:0] addr;
        write_word(0, '1, $urandom);
        write_word(TOTAL_WORDS - 1, '1, $urandom);
        read_word(0);
        issue(op_write, TOTAL_WORDS * 4, '1, $urandom);
        issue(op_read, TOTAL_WORDS * 4 + 4, '0, '0);
        idle(1);
        issue(op_write, 32'hffff_fffc, '1, $urandom);
        for (int i = 0; i < 6; i++) begin
            addr = $urandom;
            if (addr < TOTAL_WORDS * 4) begin
                addr = addr | 32'h8000_0000;
            end
            issue((i % 2 == 0) ? op_write : op_read, addr, `MEM_STRB_W'($urandom), $urandom);
        end
        idle(2);
        foreach (ref_mem[k]) begin
            read_word(k);
        end
        idle(3);
    endtask

    initial begin
        bit ok;
        int total;
        void'($urandom(57));
        req          <= 1'b0;
        req_data     <= '0;
        exp_next     <= '0;
        hold_data    = '0;
        rvalid_errs  = 0;
        err_errs     = 0;
        rdata_errs   = 0;
        timeout_errs = 0;

        wait_reset_release(ok);
        if (ok) begin
            // outputs must sit at zero before any request
            idle(4);
            full_and_partial_writes();
            bank_spread();
            out_of_range();
            wait_quiet();
        end

        total = rvalid_errs + err_errs + rdata_errs + timeout_errs;
        $display("errors: rvalid %0d, err %0d, rdata %0d, timeout %0d",
                 rvalid_errs, err_errs, rdata_errs, timeout_errs);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rsp_collector.sv
`include "mem_defs.svh"

module rsp_collector (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_pkg::rsp_tag_t       rsp_tag,
    input  logic [`MEM_DATA_W-1:0]  bank_rdata [`MEM_NO_BANKS],
    output logic                    rvalid,
    output logic [`MEM_DATA_W-1:0]  rdata,
    output logic                    err
);

    logic [`MEM_DATA_W-1:0] sel_rdata;
    logic [`MEM_DATA_W-1:0] rdata_q;

    // a rejected read reports err only
    assign rvalid = rsp_tag.valid && rsp_tag.read && !rsp_tag.error;
    assign err    = rsp_tag.valid && rsp_tag.error;

    // data of the bank that served last cycle's read
    assign sel_rdata = bank_rdata[rsp_tag.bank];

    // keeps the last read word between responses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (rvalid) begin
            rdata_q <= sel_rdata;
        end
    end

    // fresh data passes straight through
    assign rdata = rvalid ? sel_rdata : rdata_q;

endmodule

//--- run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=mem_subsys_tb

rm -rf obj_dir "$LOG"

# RTL modules have no timeunit of their own
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module "$TOP" \
    -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "TEST OK" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi

exit 0

//--- tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 3;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held low over the first rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- vlog.f
+incdir+.
mem_pkg.sv
bank_router.sv
mem_bank.sv
rsp_collector.sv
mem_subsys.sv
tb_clk_gen.sv
mem_subsys_tb.sv
